// File: rtos_params.svh
/* rtos kernel core parameters */

`ifndef RTOS_PARAMS_SVH
`define RTOS_PARAMS_SVH

// --------------------
// object counts
// --------------------
`define RTOS_TMAX_TSKID 7
`define RTOS_TMAX_SEMID 3

// --------------------
// field widths
// --------------------
`define RTOS_TSKID_W    3
`define RTOS_TSKPRI_W   3
`define RTOS_SEMID_W    2
`define RTOS_SEMCNT_W   4
`define RTOS_FLGPTN_W   4
`define RTOS_RELTIM_W   8
// holds up to all tasks in one queue
`define RTOS_QUECNT_W   3

`endif

// File: rtos_pkg.sv
/* rtos kernel shared types */

`default_nettype none

`include "rtos_params.svh"

package rtos_pkg;

    typedef logic [`RTOS_TSKID_W-1:0]  tskid_t;
    typedef logic [`RTOS_TSKPRI_W-1:0] tskpri_t;
    typedef logic [`RTOS_SEMID_W-1:0]  semid_t;
    typedef logic [`RTOS_SEMCNT_W-1:0] semcnt_t;
    typedef logic [`RTOS_FLGPTN_W-1:0] flgptn_t;
    typedef logic [`RTOS_RELTIM_W-1:0] reltim_t;
    typedef logic [`RTOS_QUECNT_W-1:0] quecnt_t;

    typedef enum logic {TS_READY, TS_WAIT} tskstat_t;

    typedef enum logic [2:0] {TW_NONE, TW_SLP, TW_DLY, TW_SEM, TW_FLG} tskwait_t;

    // host command, strobes are single cycle
    typedef struct packed {
        tskid_t  op_tskid;
        semid_t  op_semid;
        logic    wup_tsk;
        logic    slp_tsk;
        logic    dly_tsk;
        logic    sig_sem;
        logic    pol_sem;
        logic    wai_sem;
        logic    wai_flg;
        reltim_t dlytim;
        logic    wai_flg_wfmode;   // 0 and, 1 or
        flgptn_t wai_flg_ptn;
    } rtos_cmd_t;

    typedef struct packed {
        tskstat_t tskstat;
        tskwait_t tskwait;
        logic     wupcnt;
    } task_stat_t;

    typedef struct packed {
        tskid_t tskid;
        logic   valid;
    } tsk_evt_t;

endpackage

`default_nettype wire

// File: rtos_prio_queue.sv
/* id-indexed priority queue */

`timescale 1ns/1ns
`default_nettype none

module rtos_prio_queue
    import rtos_pkg::*;
#(
    parameter int QUE_SIZE = 7
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [QUE_SIZE:1]         add_mask,
    input  wire  [QUE_SIZE:1]         rmv_mask,
    input  wire  tskpri_t [QUE_SIZE:1] pri,
    output tskid_t                    top_id,
    output tskpri_t                   top_pri,
    output quecnt_t                   count
);

    // one bit per id, set means queued
    logic [QUE_SIZE:1] member;

    // --------------------
    // membership
    // --------------------

    // add first, then remove
    always_ff @(posedge clk) begin
        if (rst) begin
            member <= '0;
        end else begin
            member <= (member | add_mask) & ~rmv_mask;
        end
    end

    // --------------------
    // head search
    // --------------------

    // strict compare keeps the lower id on equal priority
    always_comb begin
        top_id  = '0;
        top_pri = '0;
        for (int i = 1; i <= QUE_SIZE; i++) begin
            if (member[i] && (top_id == '0 || pri[i] < top_pri)) begin
                top_id  = tskid_t'(i);
                top_pri = pri[i];
            end
        end
    end

    // population count
    always_comb begin
        count = '0;
        for (int i = 1; i <= QUE_SIZE; i++) begin
            count = count + quecnt_t'(member[i]);
        end
    end

endmodule

`default_nettype wire

// File: rtos_delay_timer.sv
/* task delay timer */

`timescale 1ns/1ns
`default_nettype none

module rtos_delay_timer
    import rtos_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  wire reltim_t dlytim,
    output logic         expire
);

    // zero means idle
    reltim_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            expire <= 1'b0;
        end else begin
            expire <= 1'b0;
            if (start) begin
                cnt    <= dlytim;
                // zero delay releases on the next edge
                expire <= (dlytim == '0);
            end else if (cnt != '0) begin
                cnt    <= cnt - 1'b1;
                expire <= (cnt == reltim_t'(1));
            end
        end
    end

endmodule

`default_nettype wire

// File: rtos_task.sv
/* per-task state machine */

`timescale 1ns/1ns
`default_nettype none

module rtos_task
    import rtos_pkg::*;
#(
    parameter int TSKID = 1
) (
    input  wire            clk,
    input  wire            rst,
    input  wire rtos_cmd_t cmd,
    input  wire tskid_t    run_tskid,
    input  wire flgptn_t   flgptn,
    input  wire            sem_blk,
    input  wire            sem_rel,
    output task_stat_t     stat,
    output logic           rdq_add,
    output logic           rdq_rmv,
    output logic           pending
);

    logic    is_run;
    logic    wup_hit;
    logic    flg_hit;
    logic    tmr_start;
    logic    tmr_expire;
    logic    flg_mode_q;
    flgptn_t flg_ptn_q;

    // and mode needs every pattern bit, or mode any one
    function automatic logic flg_test(input logic mode, input flgptn_t ptn,
                                      input flgptn_t cur);
        if (mode) begin
            return |(ptn & cur);
        end
        return (ptn & cur) == ptn;
    endfunction

    assign is_run    = (run_tskid == tskid_t'(TSKID)) && (stat.tskstat == TS_READY);
    assign wup_hit   = cmd.wup_tsk && (cmd.op_tskid == tskid_t'(TSKID));
    assign tmr_start = is_run && cmd.dly_tsk;
    assign flg_hit   = (stat.tskstat == TS_WAIT) && (stat.tskwait == TW_FLG) &&
                       flg_test(flg_mode_q, flg_ptn_q, flgptn);

    // a release about to fire counts as in flight too
    assign pending = rdq_add | rdq_rmv | tmr_expire | flg_hit;

    rtos_delay_timer delay_timer_i (
        .clk    (clk),
        .rst    (rst),
        .start  (tmr_start),
        .dlytim (cmd.dlytim),
        .expire (tmr_expire)
    );

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            stat.tskstat <= TS_WAIT;
            stat.tskwait <= TW_SLP;
            stat.wupcnt  <= 1'b0;
            rdq_add      <= 1'b0;
            rdq_rmv      <= 1'b0;
        end else begin
            rdq_add <= 1'b0;
            rdq_rmv <= 1'b0;
            if (stat.tskstat == TS_READY) begin
                if (wup_hit) begin
                    stat.wupcnt <= 1'b1;
                end
                if (sem_blk) begin
                    stat.tskstat <= TS_WAIT;
                    stat.tskwait <= TW_SEM;
                    rdq_rmv      <= 1'b1;
                end else if (is_run && cmd.slp_tsk) begin
                    // pending wake-up is used up instead of sleeping
                    if (stat.wupcnt) begin
                        stat.wupcnt <= 1'b0;
                    end else begin
                        stat.tskstat <= TS_WAIT;
                        stat.tskwait <= TW_SLP;
                        rdq_rmv      <= 1'b1;
                    end
                end else if (tmr_start) begin
                    stat.tskstat <= TS_WAIT;
                    stat.tskwait <= TW_DLY;
                    rdq_rmv      <= 1'b1;
                end else if (is_run && cmd.wai_flg &&
                             !flg_test(cmd.wai_flg_wfmode, cmd.wai_flg_ptn, flgptn)) begin
                    stat.tskstat <= TS_WAIT;
                    stat.tskwait <= TW_FLG;
                    rdq_rmv      <= 1'b1;
                end
            end else begin
                if (stat.tskwait == TW_SLP && wup_hit) begin
                    stat.tskstat <= TS_READY;
                    stat.tskwait <= TW_NONE;
                    rdq_add      <= 1'b1;
                end else if ((stat.tskwait == TW_DLY && tmr_expire) ||
                             (stat.tskwait == TW_SEM && sem_rel) || flg_hit) begin
                    stat.tskstat <= TS_READY;
                    stat.tskwait <= TW_NONE;
                    rdq_add      <= 1'b1;
                end else if (wup_hit) begin
                    stat.wupcnt <= 1'b1;
                end
            end
        end
    end

    // waiting pattern, taken when the wait is issued
    always_ff @(posedge clk) begin
        if (is_run && cmd.wai_flg) begin
            flg_mode_q <= cmd.wai_flg_wfmode;
            flg_ptn_q  <= cmd.wai_flg_ptn;
        end
    end

endmodule

`default_nettype wire

// File: rtos_semaphore.sv
/* counting semaphore */

`timescale 1ns/1ns
`default_nettype none

`include "rtos_params.svh"

module rtos_semaphore
    import rtos_pkg::*;
#(
    parameter int SEMID = 1
) (
    input  wire            clk,
    input  wire            rst,
    input  wire rtos_cmd_t cmd,
    input  wire tskid_t    run_tskid,
    output logic           pol_ack,
    output tsk_evt_t       blk_evt,
    output tsk_evt_t       wake_evt,
    output semcnt_t        semcnt,
    output quecnt_t        quecnt
);

    localparam int QSZ = `RTOS_TMAX_TSKID;

    logic               hit;
    logic               do_sig;
    logic               do_pol;
    logic               do_wai;
    logic    [QSZ:1]    wq_add;
    logic    [QSZ:1]    wq_rmv;
    tskpri_t [QSZ:1]    wq_pri;
    tskid_t             wq_top;

    assign hit    = (cmd.op_semid == semid_t'(SEMID));
    assign do_sig = hit && cmd.sig_sem;
    assign do_pol = hit && cmd.pol_sem;
    assign do_wai = hit && cmd.wai_sem;

    // --------------------
    // wait queue
    // --------------------

    // waiters rank the same as on the ready queue
    always_comb begin
        for (int i = 1; i <= QSZ; i++) begin
            wq_pri[i] = tskpri_t'(i);
        end
    end

    always_comb begin
        wq_add = '0;
        wq_rmv = '0;
        if (do_wai && semcnt == '0 && run_tskid != '0) begin
            wq_add[run_tskid] = 1'b1;
        end
        if (do_sig && wq_top != '0) begin
            wq_rmv[wq_top] = 1'b1;
        end
    end

    rtos_prio_queue #(
        .QUE_SIZE (QSZ)
    ) wait_queue_i (
        .clk      (clk),
        .rst      (rst),
        .add_mask (wq_add),
        .rmv_mask (wq_rmv),
        .pri      (wq_pri),
        .top_id   (wq_top),
        .top_pri  (),
        .count    (quecnt)
    );

    // --------------------
    // count and events
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            semcnt   <= '0;
            pol_ack  <= 1'b0;
            blk_evt  <= '0;
            wake_evt <= '0;
        end else begin
            pol_ack  <= 1'b0;
            blk_evt  <= '0;
            wake_evt <= '0;
            if (do_sig) begin
                if (wq_top != '0) begin
                    wake_evt <= '{tskid: wq_top, valid: 1'b1};
                end else if (semcnt != '1) begin
                    semcnt <= semcnt + 1'b1;
                end
            end else if (do_wai) begin
                if (semcnt != '0) begin
                    semcnt <= semcnt - 1'b1;
                end else if (run_tskid != '0) begin
                    blk_evt <= '{tskid: run_tskid, valid: 1'b1};
                end
            end else if (do_pol && semcnt != '0) begin
                semcnt  <= semcnt - 1'b1;
                pol_ack <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtos_core.sv
/* rtos kernel core top level */

`timescale 1ns/1ns
`default_nettype none

`include "rtos_params.svh"

module rtos_core
    import rtos_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire rtos_cmd_t cmd,
    input  wire flgptn_t   set_flg,
    input  wire flgptn_t   clr_flg,
    output logic           busy,
    output tskid_t         run_tskid,
    output tskpri_t        run_tskpri,
    output quecnt_t        rdq_quecnt,
    output task_stat_t [`RTOS_TMAX_TSKID:1] task_stat,
    output semcnt_t    [`RTOS_TMAX_SEMID:1] sem_cnt,
    output quecnt_t    [`RTOS_TMAX_SEMID:1] sem_quecnt,
    output flgptn_t        flgptn,
    output logic           pol_sem_ack
);

    localparam int NTSK = `RTOS_TMAX_TSKID;
    localparam int NSEM = `RTOS_TMAX_SEMID;

    logic    [NTSK:1] task_rdq_add;
    logic    [NTSK:1] task_rdq_rmv;
    logic    [NTSK:1] task_pending;
    logic    [NTSK:1] sem_blk;
    logic    [NTSK:1] sem_rel;
    tskpri_t [NTSK:1] rdq_pri;

    logic     [NSEM:1] sem_pol_ack;
    tsk_evt_t [NSEM:1] sem_blk_evt;
    tsk_evt_t [NSEM:1] sem_wake_evt;
    tsk_evt_t          blk_any;
    tsk_evt_t          wake_any;

    // --------------------
    // ready queue
    // --------------------
    rtos_prio_queue #(
        .QUE_SIZE (NTSK)
    ) ready_queue_i (
        .clk      (clk),
        .rst      (rst),
        .add_mask (task_rdq_add),
        .rmv_mask (task_rdq_rmv),
        .pri      (rdq_pri),
        .top_id   (run_tskid),
        .top_pri  (run_tskpri),
        .count    (rdq_quecnt)
    );

    // --------------------
    // tasks
    // --------------------
    for (genvar i = 1; i <= NTSK; i++) begin : g_task
        // fixed priority equals the id
        assign rdq_pri[i] = tskpri_t'(i);

        rtos_task #(
            .TSKID (i)
        ) task_i (
            .clk       (clk),
            .rst       (rst),
            .cmd       (cmd),
            .run_tskid (run_tskid),
            .flgptn    (flgptn),
            .sem_blk   (sem_blk[i]),
            .sem_rel   (sem_rel[i]),
            .stat      (task_stat[i]),
            .rdq_add   (task_rdq_add[i]),
            .rdq_rmv   (task_rdq_rmv[i]),
            .pending   (task_pending[i])
        );
    end

    // --------------------
    // semaphores
    // --------------------
    for (genvar s = 1; s <= NSEM; s++) begin : g_sem
        rtos_semaphore #(
            .SEMID (s)
        ) sem_i (
            .clk       (clk),
            .rst       (rst),
            .cmd       (cmd),
            .run_tskid (run_tskid),
            .pol_ack   (sem_pol_ack[s]),
            .blk_evt   (sem_blk_evt[s]),
            .wake_evt  (sem_wake_evt[s]),
            .semcnt    (sem_cnt[s]),
            .quecnt    (sem_quecnt[s])
        );
    end

    // only the addressed semaphore ever fires, so an or is enough
    always_comb begin
        blk_any  = '0;
        wake_any = '0;
        for (int s = 1; s <= NSEM; s++) begin
            blk_any  = blk_any | sem_blk_evt[s];
            wake_any = wake_any | sem_wake_evt[s];
        end
        sem_blk = '0;
        sem_rel = '0;
        if (blk_any.valid && blk_any.tskid != '0) begin
            sem_blk[blk_any.tskid] = 1'b1;
        end
        if (wake_any.valid && wake_any.tskid != '0) begin
            sem_rel[wake_any.tskid] = 1'b1;
        end
    end

    // event flag, set then clear
    always_ff @(posedge clk) begin
        if (rst) begin
            flgptn <= '0;
        end else begin
            flgptn <= (flgptn | set_flg) & ~clr_flg;
        end
    end

    assign pol_sem_ack = |sem_pol_ack;
    assign busy        = |task_pending | blk_any.valid | wake_any.valid;

endmodule

`default_nettype wire

// File: tb_rtos_core.sv
/* rtos core testbench */

`timescale 1ns/1ns
`default_nettype none

`include "rtos_params.svh"

module tb_rtos_core
    import rtos_pkg::*;
();

    localparam int NTSK = `RTOS_TMAX_TSKID;
    localparam int NSEM = `RTOS_TMAX_SEMID;

    typedef struct packed {
        rtos_cmd_t  cmd;
        flgptn_t    set_flg;
        flgptn_t    clr_flg;
        logic       wait_busy;
        logic       has_exp;
        tskid_t     exp_run;
        quecnt_t    exp_cnt;
        tskid_t     sel_tsk;
        task_stat_t exp_stat;
        semid_t     sel_sem;     // 0 selects flgptn
        logic [3:0] exp_val;
    } step_t;

    logic      clk;
    logic      rst;
    rtos_cmd_t cmd;
    flgptn_t   set_flg;
    flgptn_t   clr_flg;

    logic                    busy;
    tskid_t                  run_tskid;
    tskpri_t                 run_tskpri;
    quecnt_t                 rdq_quecnt;
    task_stat_t [NTSK:1]     task_stat;
    semcnt_t    [NSEM:1]     sem_cnt;
    quecnt_t    [NSEM:1]     sem_quecnt;
    flgptn_t                 flgptn;
    logic                    pol_sem_ack;

    step_t steps[$];
    int    errors;
    logic  table_ready;

    // reference model state
    task_stat_t    m_stat [1:NTSK];
    logic          m_mode [1:NTSK];
    flgptn_t       m_ptn [1:NTSK];
    semcnt_t       m_semcnt [1:NSEM];
    logic [NTSK:1] m_semq [1:NSEM];
    flgptn_t       m_flg;
    logic          m_ack;

    rtos_core rtos_core_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .set_flg     (set_flg),
        .clr_flg     (clr_flg),
        .busy        (busy),
        .run_tskid   (run_tskid),
        .run_tskpri  (run_tskpri),
        .rdq_quecnt  (rdq_quecnt),
        .task_stat   (task_stat),
        .sem_cnt     (sem_cnt),
        .sem_quecnt  (sem_quecnt),
        .flgptn      (flgptn),
        .pol_sem_ack (pol_sem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic task_stat_t mk_stat(input tskstat_t s, input tskwait_t w, input logic u);
        task_stat_t st;
        st.tskstat = s;
        st.tskwait = w;
        st.wupcnt  = u;
        return st;
    endfunction

    // and needs all pattern bits, or needs one
    function automatic logic flag_met(input logic mode, input flgptn_t ptn, input flgptn_t cur);
        if (mode) begin
            return (ptn & cur) != '0;
        end
        return (ptn & cur) == ptn;
    endfunction

    // lowest id runs first since priority equals id
    function automatic tskid_t model_run();
        for (int i = 1; i <= NTSK; i++) begin
            if (m_stat[i].tskstat == TS_READY) begin
                return tskid_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic int model_count();
        int n;
        n = 0;
        for (int i = 1; i <= NTSK; i++) begin
            n += (m_stat[i].tskstat == TS_READY) ? 1 : 0;
        end
        return n;
    endfunction

    task automatic set_ready(input int i);
        m_stat[i].tskstat = TS_READY;
        m_stat[i].tskwait = TW_NONE;
    endtask

    task automatic set_wait(input int i, input tskwait_t w);
        m_stat[i].tskstat = TS_WAIT;
        m_stat[i].tskwait = w;
    endtask

    task automatic model_reset();
        for (int i = 1; i <= NTSK; i++) begin
            m_stat[i] = mk_stat(TS_WAIT, TW_SLP, 1'b0);
            m_mode[i] = 1'b0;
            m_ptn[i]  = '0;
        end
        for (int s = 1; s <= NSEM; s++) begin
            m_semcnt[s] = '0;
            m_semq[s]   = '0;
        end
        m_flg = '0;
        m_ack = 1'b0;
    endtask

    // a timed delay is settled as a whole and leaves the caller ready
    task automatic model_apply(input step_t st);
        int run;
        int id;
        int s;
        int rel;
        run   = int'(model_run());
        id    = int'(st.cmd.op_tskid);
        s     = int'(st.cmd.op_semid);
        rel   = 0;
        m_ack = 1'b0;
        if (st.cmd.wup_tsk && id != 0) begin
            if (m_stat[id].tskstat == TS_WAIT && m_stat[id].tskwait == TW_SLP) begin
                set_ready(id);
            end else begin
                m_stat[id].wupcnt = 1'b1;
            end
        end
        if (st.cmd.slp_tsk && run != 0) begin
            if (m_stat[run].wupcnt) begin
                m_stat[run].wupcnt = 1'b0;
            end else begin
                set_wait(run, TW_SLP);
            end
        end
        if (st.cmd.wai_flg && run != 0 &&
            !flag_met(st.cmd.wai_flg_wfmode, st.cmd.wai_flg_ptn, m_flg)) begin
            set_wait(run, TW_FLG);
            m_mode[run] = st.cmd.wai_flg_wfmode;
            m_ptn[run]  = st.cmd.wai_flg_ptn;
        end
        if (s >= 1 && st.cmd.sig_sem) begin
            if (m_semq[s] != '0) begin
                for (int i = NTSK; i >= 1; i--) begin
                    if (m_semq[s][i]) begin
                        rel = i;
                    end
                end
                m_semq[s][rel] = 1'b0;
                set_ready(rel);
            end else if (m_semcnt[s] != 4'hf) begin
                m_semcnt[s] = m_semcnt[s] + 4'd1;
            end
        end
        if (s >= 1 && st.cmd.wai_sem) begin
            if (m_semcnt[s] != '0) begin
                m_semcnt[s] = m_semcnt[s] - 4'd1;
            end else if (run != 0) begin
                m_semq[s][run] = 1'b1;
                set_wait(run, TW_SEM);
            end
        end
        if (s >= 1 && st.cmd.pol_sem && m_semcnt[s] != '0) begin
            m_semcnt[s] = m_semcnt[s] - 4'd1;
            m_ack       = 1'b1;
        end
        m_flg = (m_flg | st.set_flg) & ~st.clr_flg;
        for (int i = 1; i <= NTSK; i++) begin
            if (m_stat[i].tskstat == TS_WAIT && m_stat[i].tskwait == TW_FLG &&
                flag_met(m_mode[i], m_ptn[i], m_flg)) begin
                set_ready(i);
            end
        end
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_dut();
        check_value("run_tskid", 8'(run_tskid), 8'(model_run()));
        // fixed priority equals the running id
        check_value("run_tskpri", 8'(run_tskpri), 8'(model_run()));
        check_value("rdq_quecnt", 8'(rdq_quecnt), 8'(model_count()));
        for (int i = 1; i <= NTSK; i++) begin
            check_value($sformatf("task_stat[%0d]", i), 8'(task_stat[i]), 8'(m_stat[i]));
        end
        for (int s = 1; s <= NSEM; s++) begin
            check_value($sformatf("sem_cnt[%0d]", s), 8'(sem_cnt[s]), 8'(m_semcnt[s]));
            check_value($sformatf("sem_quecnt[%0d]", s), 8'(sem_quecnt[s]),
                        8'($countones(m_semq[s])));
        end
        check_value("flgptn", 8'(flgptn), 8'(m_flg));
    endtask

    task automatic check_table(input step_t st, input int idx);
        logic [3:0] model_val;
        if (st.has_exp) begin
            if (st.sel_sem == '0) begin
                model_val = m_flg;
            end else begin
                model_val = m_semcnt[st.sel_sem];
            end
            assert (st.exp_run == model_run() && int'(st.exp_cnt) == model_count() &&
                    st.exp_stat == m_stat[st.sel_tsk] && st.exp_val == model_val)
            else begin
                errors++;
                $display("step %0d: table entry disagrees with the reference model", idx);
            end
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic apply_step(input step_t st, input int idx);
        tskid_t caller;
        logic   ack_seen;
        int     waited;
        caller  = model_run();
        cmd     = st.cmd;
        set_flg = st.set_flg;
        clr_flg = st.clr_flg;
        @(negedge clk);
        ack_seen = pol_sem_ack;
        cmd      = '0;
        set_flg  = '0;
        clr_flg  = '0;
        model_apply(st);
        check_value("pol_sem_ack", 8'(ack_seen), 8'(m_ack));
        // a satisfied flag wait keeps the caller ready from the first cycle on
        if (st.cmd.wai_flg && caller != '0 && m_stat[caller].tskstat == TS_READY) begin
            check_value($sformatf("task_stat[%0d]", caller), 8'(task_stat[caller]),
                        8'(m_stat[caller]));
        end
        if (st.cmd.dly_tsk && caller != '0) begin
            repeat (int'(st.cmd.dlytim)) @(negedge clk);
            check_value($sformatf("task_stat[%0d]", caller), 8'(task_stat[caller]),
                        8'(mk_stat(TS_WAIT, TW_DLY, m_stat[caller].wupcnt)));
            @(negedge clk);
            check_value($sformatf("task_stat[%0d]", caller), 8'(task_stat[caller]),
                        8'(mk_stat(TS_READY, TW_NONE, m_stat[caller].wupcnt)));
        end
        @(negedge clk);
        // ack lasts one cycle only
        check_value("pol_sem_ack", 8'(pol_sem_ack), 8'h00);
        if (st.wait_busy) begin
            waited = 0;
            while (busy && waited < 10) begin
                @(negedge clk);
                waited++;
            end
            assert (!busy) else begin
                errors++;
                $display("step %0d: busy stayed high for 10 cycles", idx);
            end
        end
        check_table(st, idx);
        compare_dut();
    endtask

    function automatic rtos_cmd_t wake_cmd(input int id);
        rtos_cmd_t c;
        c          = '0;
        c.wup_tsk  = 1'b1;
        c.op_tskid = tskid_t'(id);
        return c;
    endfunction

    function automatic rtos_cmd_t sleep_cmd();
        rtos_cmd_t c;
        c         = '0;
        c.slp_tsk = 1'b1;
        return c;
    endfunction

    function automatic rtos_cmd_t delay_cmd(input int d);
        rtos_cmd_t c;
        c         = '0;
        c.dly_tsk = 1'b1;
        c.dlytim  = reltim_t'(d);
        return c;
    endfunction

    // op 0 signal, 1 poll, 2 wait
    function automatic rtos_cmd_t sem_cmd(input int op, input int s);
        rtos_cmd_t c;
        c          = '0;
        c.op_semid = semid_t'(s);
        c.sig_sem  = (op == 0);
        c.pol_sem  = (op == 1);
        c.wai_sem  = (op == 2);
        return c;
    endfunction

    function automatic rtos_cmd_t flag_wait_cmd(input logic mode, input flgptn_t ptn);
        rtos_cmd_t c;
        c                = '0;
        c.wai_flg        = 1'b1;
        c.wai_flg_wfmode = mode;
        c.wai_flg_ptn    = ptn;
        return c;
    endfunction

    task automatic add_step(input rtos_cmd_t c, input flgptn_t sf, input flgptn_t cf);
        step_t st;
        st           = '0;
        st.cmd       = c;
        st.set_flg   = sf;
        st.clr_flg   = cf;
        st.wait_busy = 1'b1;
        steps.push_back(st);
    endtask

    task automatic expect_last(input int run, input int cnt, input int sel,
                               input task_stat_t stat, input int ss, input int val);
        step_t st;
        st          = steps.pop_back();
        st.has_exp  = 1'b1;
        st.exp_run  = tskid_t'(run);
        st.exp_cnt  = quecnt_t'(cnt);
        st.sel_tsk  = tskid_t'(sel);
        st.exp_stat = stat;
        st.sel_sem  = semid_t'(ss);
        st.exp_val  = 4'(val);
        steps.push_back(st);
    endtask

    task automatic build_table();
        int         order [3];
        int         tmp;
        int         j;
        task_stat_t rdy;
        rdy      = mk_stat(TS_READY, TW_NONE, 1'b0);
        order[0] = 5;
        order[1] = 2;
        order[2] = 6;
        for (int i = 2; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // scheduling and wake-up count
        for (int i = 0; i < 3; i++) begin
            add_step(wake_cmd(order[i]), '0, '0);
        end
        expect_last(2, 3, 2, rdy, 0, 0);
        add_step(sleep_cmd(), '0, '0);
        expect_last(5, 2, 2, mk_stat(TS_WAIT, TW_SLP, 1'b0), 0, 0);
        add_step(wake_cmd(5), '0, '0);
        expect_last(5, 2, 5, mk_stat(TS_READY, TW_NONE, 1'b1), 0, 0);
        add_step(sleep_cmd(), '0, '0);
        expect_last(5, 2, 5, rdy, 0, 0);
        add_step(delay_cmd(3), '0, '0);
        expect_last(5, 2, 5, rdy, 0, 0);
        // semaphore wait and signal
        add_step(wake_cmd(3), '0, '0);
        expect_last(3, 3, 3, rdy, 1, 0);
        add_step(sem_cmd(2, 1), '0, '0);
        expect_last(5, 2, 3, mk_stat(TS_WAIT, TW_SEM, 1'b0), 1, 0);
        add_step(sem_cmd(2, 1), '0, '0);
        expect_last(6, 1, 5, mk_stat(TS_WAIT, TW_SEM, 1'b0), 1, 0);
        add_step(sem_cmd(0, 1), '0, '0);
        expect_last(3, 2, 3, rdy, 1, 0);
        add_step(sem_cmd(0, 1), '0, '0);
        expect_last(3, 3, 5, rdy, 1, 0);
        add_step(sem_cmd(0, 1), '0, '0);
        expect_last(3, 3, 3, rdy, 1, 1);
        add_step(sem_cmd(0, 2), '0, '0);
        expect_last(3, 3, 3, rdy, 2, 1);
        // poll
        add_step(sem_cmd(1, 2), '0, '0);
        expect_last(3, 3, 3, rdy, 2, 0);
        add_step(sem_cmd(1, 2), '0, '0);
        expect_last(3, 3, 3, rdy, 2, 0);
        add_step(sem_cmd(2, 1), '0, '0);
        expect_last(3, 3, 3, rdy, 1, 0);
        // event flag
        add_step('0, 4'b1011, 4'b0010);
        expect_last(3, 3, 3, rdy, 0, 'h9);
        add_step('0, 4'b0110, 4'b0110);
        expect_last(3, 3, 3, rdy, 0, 'h9);
        add_step(flag_wait_cmd(1'b0, 4'b1100), '0, '0);
        expect_last(5, 2, 3, mk_stat(TS_WAIT, TW_FLG, 1'b0), 0, 'h9);
        add_step('0, 4'b0010, '0);
        expect_last(5, 2, 3, mk_stat(TS_WAIT, TW_FLG, 1'b0), 0, 'hb);
        add_step('0, 4'b0100, '0);
        expect_last(3, 3, 3, rdy, 0, 'hf);
        add_step(flag_wait_cmd(1'b1, 4'b0001), '0, '0);
        expect_last(3, 3, 3, rdy, 0, 'hf);
        add_step('0, '0, 4'b1111);
        expect_last(3, 3, 3, rdy, 0, 0);
        // random tail checked against the model only
        add_step(delay_cmd(int'($urandom % 30) + 1), '0, '0);
        add_step(sleep_cmd(), '0, '0);
        add_step(delay_cmd(int'($urandom % 30) + 1), '0, '0);
        add_step(wake_cmd(3), '0, '0);
        add_step(delay_cmd(int'($urandom % 30) + 1), '0, '0);
    endtask

    initial begin
        void'($urandom(66898));
        errors      = 0;
        table_ready = 1'b0;
        rst         = 1'b1;
        cmd         = '0;
        set_flg     = '0;
        clr_flg     = '0;
        build_table();
        model_reset();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_dut();
        foreach (steps[i]) begin
            apply_step(steps[i], i);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = steps.size() * 20 + 300;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("errors: %0d", errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
rtos_pkg.sv
rtos_prio_queue.sv
rtos_delay_timer.sv
rtos_task.sv
rtos_semaphore.sv
rtos_core.sv
tb_rtos_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rtos core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_rtos_core -o sim_rtos_core
./obj_dir/sim_rtos_core | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
